//--- rtl/periph_consts.svh
// ********************
// Width and timing constants shared by the audio and gamepad paths.
// Included by the packages and by any module that sizes logic from them.
// ********************

`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Signed PCM sample width per channel
`define PCM_BITS 16

// Delta-sigma DAC output width per channel
`define DAC_BITS 4

// clk_2x cycles between sample loads into the DAC
`define DAC_FRAME 16

// Buttons read out serially, bit 0 first
`define PAD_BUTTONS 12

`endif

//--- rtl/audio_pkg.sv
// ********************
// Audio path types.
// Stereo sample layout and the DAC channel index.
// ********************

`include "periph_consts.svh"

package audio_pkg;

    // One stereo PCM sample as delivered by the console core
    typedef struct packed {
        logic signed [`PCM_BITS-1:0] left;
        logic signed [`PCM_BITS-1:0] right;
    } stereo_sample_t;

    // Selects one of the two modulators
    typedef enum logic {
        CHAN_L = 1'b0,
        CHAN_R = 1'b1
    } dac_chan_e;

endpackage

//--- rtl/pad_pkg.sv
// ********************
// Gamepad path types.
// Button word in classic pad order and the serial read states.
// ********************

`include "periph_consts.svh"

package pad_pkg;

    // Last field is bit 0, so b is the first bit read out
    // A set bit means pressed
    typedef struct packed {
        logic r;
        logic l;
        logic x;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic y;
        logic b;
    } pad_buttons_t;

    typedef enum logic [1:0] {
        PAD_IDLE     = 2'd0,
        PAD_SHIFTING = 2'd1,
        PAD_DONE     = 2'd2
    } pad_shift_e;

endpackage

//--- rtl/audio_sample_latch.sv
// ********************
// One-entry holding stage between the core's sample handshake
// and the DAC, which only takes samples at frame boundaries.
// ********************

module audio_sample_latch
    import audio_pkg::*;
(
    input  logic           clk_2x,
    input  logic           rst_n,

    input  logic           sample_valid,
    output logic           sample_ready,
    input  stereo_sample_t sample,

    output logic           hold_valid,
    input  logic           hold_ready,
    output stereo_sample_t hold
);

    logic full;
    logic take_in;
    logic take_out;

    // Room when empty or when the held sample leaves this cycle
    assign sample_ready = !full || hold_ready;
    assign take_in      = sample_valid && sample_ready;
    assign take_out     = full && hold_ready;
    assign hold_valid   = full;

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (take_in) begin
            full <= 1'b1;
        end else if (take_out) begin
            full <= 1'b0;
        end
    end

    // Sample register
    always_ff @(posedge clk_2x) begin
        if (take_in) begin
            hold <= sample;
        end
    end

    // A stalled sample may not change under the DAC
    hold_stable_a: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        (hold_valid && !hold_ready) |=> (hold_valid && $stable(hold))
    ) else $error("hold changed while stalled at %0t", $time);

endmodule

//--- rtl/audio_dac_sd.sv
// ********************
// Two-channel first-order delta-sigma DAC.
// Takes a new stereo sample once per frame and drives 4-bit
// outputs whose running average follows the sample value.
// ********************

`include "periph_consts.svh"

module audio_dac_sd
    import audio_pkg::*;
(
    input  logic                 clk_2x,
    input  logic                 rst_n,

    input  logic                 hold_valid,
    output logic                 hold_ready,
    input  stereo_sample_t       hold,

    output logic [`DAC_BITS-1:0] dac_l,
    output logic [`DAC_BITS-1:0] dac_r
);

    localparam int ACC_BITS = `PCM_BITS - `DAC_BITS;
    localparam int NUM_CHAN = int'(CHAN_R) + 1;
    localparam int CNT_BITS = $clog2(`DAC_FRAME);
    localparam logic [CNT_BITS-1:0]  FRAME_LAST = CNT_BITS'(`DAC_FRAME - 1);
    localparam logic [`DAC_BITS-1:0] DAC_MAX = '1;
    // Zero sample in offset form
    localparam logic [`PCM_BITS-1:0] PCM_MID = {1'b1, {(`PCM_BITS-1){1'b0}}};
    localparam logic [`DAC_BITS-1:0] DAC_MID = PCM_MID[`PCM_BITS-1 -: `DAC_BITS];

    logic [CNT_BITS-1:0]  frame_cnt;
    logic                 load;

    logic [`PCM_BITS-1:0] in_off  [NUM_CHAN];
    logic [`PCM_BITS-1:0] pcm_off [NUM_CHAN];
    logic [`DAC_BITS-1:0] coarse  [NUM_CHAN];
    logic [ACC_BITS:0]    acc_sum [NUM_CHAN];
    logic [ACC_BITS-1:0]  acc     [NUM_CHAN];
    logic [`DAC_BITS-1:0] dac_q   [NUM_CHAN];

    // Frame boundary every DAC_FRAME cycles from reset
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (frame_cnt == FRAME_LAST) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign hold_ready = (frame_cnt == FRAME_LAST);
    assign load       = hold_valid && hold_ready;

    // Signed to offset binary by flipping the sign bit
    assign in_off[CHAN_L] = {~hold.left[`PCM_BITS-1], hold.left[`PCM_BITS-2:0]};
    assign in_off[CHAN_R] = {~hold.right[`PCM_BITS-1], hold.right[`PCM_BITS-2:0]};

    always_comb begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            coarse[ch]  = pcm_off[ch][`PCM_BITS-1 -: `DAC_BITS];
            acc_sum[ch] = {1'b0, acc[ch]} + {1'b0, pcm_off[ch][ACC_BITS-1:0]};
        end
    end

    // Coarse code plus the accumulator carry as a one-LSB dither
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                pcm_off[ch] <= PCM_MID;
                acc[ch]     <= '0;
                dac_q[ch]   <= DAC_MID;
            end
        end else begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                if (load) begin
                    pcm_off[ch] <= in_off[ch];
                end
                if (coarse[ch] == DAC_MAX) begin
                    // Full scale, carry would overflow the output
                    dac_q[ch] <= DAC_MAX;
                end else begin
                    acc[ch]   <= acc_sum[ch][ACC_BITS-1:0];
                    dac_q[ch] <= coarse[ch] + {{(`DAC_BITS-1){1'b0}}, acc_sum[ch][ACC_BITS]};
                end
            end
        end
    end

    assign dac_l = dac_q[CHAN_L];
    assign dac_r = dac_q[CHAN_R];

    // One-cycle ready pulse per frame
    ready_pulse_a: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        hold_ready |=> !hold_ready
    ) else $error("hold_ready high on consecutive cycles at %0t", $time);

endmodule

//--- rtl/pad_button_sync.sv
// ********************
// Brings the gamepad buttons into the clk_2x domain.
// USE_USB_PAD picks the USB reader or the board buttons.
// ********************

module pad_button_sync
    import pad_pkg::*;
#(
    parameter bit USE_USB_PAD = 1'b1
) (
    input  logic         clk_2x,
    input  logic         rst_n,

    input  pad_buttons_t usb_btn,
    input  pad_buttons_t board_btn,
    output pad_buttons_t btn_sync
);

    pad_buttons_t btn_src;
    pad_buttons_t btn_meta;

    assign btn_src = USE_USB_PAD ? usb_btn : board_btn;

    // Two-flop synchronizer, all released at reset
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= btn_src;
            btn_sync <= btn_meta;
        end
    end

endmodule

//--- rtl/pad_shift_reg.sv
// ********************
// Classic pad shift register seen from the core.
// pad_latch loads the buttons, each pad_clk rise shifts one bit,
// and ones follow once all buttons are out.
// ********************

`include "periph_consts.svh"

module pad_shift_reg
    import pad_pkg::*;
(
    input  logic         clk_2x,
    input  logic         rst_n,

    input  pad_buttons_t btn_sync,
    input  logic         pad_latch,
    input  logic         pad_clk,
    output logic         pad_data
);

    localparam int CNT_BITS = $clog2(`PAD_BUTTONS + 1);
    localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`PAD_BUTTONS - 1);

    pad_shift_e               state;
    logic [`PAD_BUTTONS-1:0]  shreg;
    logic [CNT_BITS-1:0]      bit_cnt;
    logic                     pad_clk_q;
    logic                     clk_rise_q;

    // Registered rising-edge detect on pad_clk
    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            pad_clk_q  <= 1'b0;
            clk_rise_q <= 1'b0;
        end else begin
            pad_clk_q  <= pad_clk;
            clk_rise_q <= pad_clk && !pad_clk_q;
        end
    end

    always_ff @(posedge clk_2x) begin
        if (!rst_n) begin
            state   <= PAD_IDLE;
            shreg   <= '1;
            bit_cnt <= '0;
        end else if (pad_latch) begin
            // Track the buttons until the latch drops
            state   <= PAD_IDLE;
            shreg   <= btn_sync;
            bit_cnt <= '0;
        end else if (clk_rise_q) begin
            case (state)
                PAD_IDLE, PAD_SHIFTING: begin
                    shreg   <= {1'b1, shreg[`PAD_BUTTONS-1:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_LAST) begin
                        state <= PAD_DONE;
                    end else begin
                        state <= PAD_SHIFTING;
                    end
                end
                // All ones from here on
                default: begin
                    state <= PAD_DONE;
                end
            endcase
        end
    end

    assign pad_data = shreg[0];

    // Latch must pull the reader out of a read in progress
    latch_idle_a: assert property (
        @(posedge clk_2x) disable iff (!rst_n)
        pad_latch |=> (state != PAD_SHIFTING)
    ) else $error("shifting while pad_latch high at %0t", $time);

endmodule

//--- rtl/periph_top.sv
// ********************
// Peripheral block top level.
// Audio chain: sample latch into the delta-sigma DAC.
// Gamepad chain: button sync into the serial pad reader.
// ********************

`include "periph_consts.svh"

module periph_top
    import audio_pkg::*;
    import pad_pkg::*;
#(
    parameter bit USE_USB_PAD = 1'b1
) (
    input  logic                 clk_2x,
    input  logic                 rst_n,

    // Audio from the core
    input  logic                 sample_valid,
    output logic                 sample_ready,
    input  stereo_sample_t       sample,

    output logic [`DAC_BITS-1:0] dac_l,
    output logic [`DAC_BITS-1:0] dac_r,

    // Gamepad
    input  pad_buttons_t         usb_btn,
    input  pad_buttons_t         board_btn,
    input  logic                 pad_latch,
    input  logic                 pad_clk,
    output logic                 pad_data
);

    logic           hold_valid;
    logic           hold_ready;
    stereo_sample_t hold;
    pad_buttons_t   btn_sync;

    audio_sample_latch u_sample_latch (
        .clk_2x       (clk_2x),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample       (sample),
        .hold_valid   (hold_valid),
        .hold_ready   (hold_ready),
        .hold         (hold)
    );

    audio_dac_sd u_dac (
        .clk_2x     (clk_2x),
        .rst_n      (rst_n),
        .hold_valid (hold_valid),
        .hold_ready (hold_ready),
        .hold       (hold),
        .dac_l      (dac_l),
        .dac_r      (dac_r)
    );

    pad_button_sync #(
        .USE_USB_PAD (USE_USB_PAD)
    ) u_btn_sync (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .usb_btn   (usb_btn),
        .board_btn (board_btn),
        .btn_sync  (btn_sync)
    );

    pad_shift_reg u_pad_reader (
        .clk_2x    (clk_2x),
        .rst_n     (rst_n),
        .btn_sync  (btn_sync),
        .pad_latch (pad_latch),
        .pad_clk   (pad_clk),
        .pad_data  (pad_data)
    );

endmodule

//--- dv/tb_periph_top.sv
// ********************
// Testbench for the peripheral block top level.
// Streams audio samples, checks DAC averages and reads the gamepad serially.
// Concurrent assertions count failures; a closing line reports the total.
// ********************

`include "periph_consts.svh"

module tb_periph_top
    import audio_pkg::*;
    import pad_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int HIST_LEN       = 4 * `DAC_FRAME;
    localparam int MAX_XFER       = 5;
    localparam int MAX_BURST      = 2;
    localparam int AVG_CYCLES     = 1 << (`PCM_BITS - `DAC_BITS);
    localparam int FULL_SUM       = ((1 << `DAC_BITS) - 1) * AVG_CYCLES;
    localparam logic [`DAC_BITS-1:0] DAC_TOP      = '1;
    localparam logic [`DAC_BITS-1:0] DAC_MID      = {1'b1, {(`DAC_BITS-1){1'b0}}};
    localparam logic [`DAC_BITS-1:0] PCM_TOP_FULL = {1'b0, {(`DAC_BITS-1){1'b1}}};
    localparam logic signed [`PCM_BITS-1:0] PCM_MAX = {1'b0, {(`PCM_BITS-1){1'b1}}};

    logic                 clk_2x;
    logic                 rst_n;
    logic                 sample_valid;
    logic                 sample_ready;
    stereo_sample_t       sample;
    logic [`DAC_BITS-1:0] dac_l;
    logic [`DAC_BITS-1:0] dac_r;
    pad_buttons_t         usb_btn;
    pad_buttons_t         board_btn;
    logic                 pad_latch;
    logic                 pad_clk;
    logic                 pad_data;

    integer               seed = 32'h4835_6b0b;
    int                   err_cnt = 0;
    int                   cycle_cnt;
    logic                 xfer;
    logic [HIST_LEN-1:0]  xfer_hist;
    int                   burst_cnt;
    logic                 reset_chk;
    logic                 avg_chk;
    int                   sum_l;
    int                   sum_r;
    int                   exp_l;
    int                   exp_r;
    logic                 pad_chk;
    logic                 pad_exp;

    periph_top #(
        .USE_USB_PAD (1'b1)
    ) UUT (
        .clk_2x       (clk_2x),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample       (sample),
        .dac_l        (dac_l),
        .dac_r        (dac_r),
        .usb_btn      (usb_btn),
        .board_btn    (board_btn),
        .pad_latch    (pad_latch),
        .pad_clk      (pad_clk),
        .pad_data     (pad_data)
    );

    initial begin
        clk_2x = 1'b0;
        forever #(CLK_PERIOD / 2) clk_2x = ~clk_2x;
    end

    // Transfer history over the last four frames, plus back-to-back run length
    assign xfer = sample_valid && sample_ready;

    always @(posedge clk_2x) begin
        if (!rst_n) begin
            xfer_hist <= '0;
            burst_cnt <= 0;
        end else begin
            xfer_hist <= {xfer_hist[HIST_LEN-2:0], xfer};
            burst_cnt <= xfer ? burst_cnt + 1 : 0;
        end
    end

    reset_a: assert property (@(posedge clk_2x) disable iff (!rst_n)
        reset_chk |-> (sample_ready && pad_data && dac_l == DAC_MID && dac_r == DAC_MID))
    else begin
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: after reset ready=%0b pad_data=%0b dac_l=%0d dac_r=%0d",
                 $time, sample_ready, pad_data, dac_l, dac_r);
    end

    burst_a: assert property (@(posedge clk_2x) disable iff (!rst_n)
        burst_cnt <= MAX_BURST)
    else begin
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: %0d transfers in a row", $time, burst_cnt);
    end

    window_a: assert property (@(posedge clk_2x) disable iff (!rst_n)
        $countones(xfer_hist) <= MAX_XFER)
    else begin
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: %0d transfers within %0d cycles",
                 $time, $countones(xfer_hist), HIST_LEN);
    end

    avg_a: assert property (@(posedge clk_2x) disable iff (!rst_n)
        avg_chk |-> (sum_l == exp_l && sum_r == exp_r))
    else begin
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: DAC sums L=%0d R=%0d, expected L=%0d R=%0d",
                 $time, sum_l, sum_r, exp_l, exp_r);
    end

    pad_a: assert property (@(posedge clk_2x) disable iff (!rst_n)
        pad_chk |-> (pad_data == pad_exp))
    else begin
        err_cnt = err_cnt + 1;
        $display("Error at time %0t: pad_data=%0b, expected %0b", $time, pad_data, pad_exp);
    end

    function automatic stereo_sample_t rand_sample();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    function automatic logic [`PAD_BUTTONS-1:0] rand_buttons();
        logic [31:0] r;
        r = $random(seed);
        return r[`PAD_BUTTONS-1:0];
    endfunction

    // Offset top bits all ones means the signed top bits read 0111
    function automatic logic signed [`PCM_BITS-1:0] below_full_scale(
        input logic signed [`PCM_BITS-1:0] pcm
    );
        logic signed [`PCM_BITS-1:0] v;
        v = pcm;
        if (v[`PCM_BITS-1 -: `DAC_BITS] == PCM_TOP_FULL) begin
            v[`PCM_BITS-`DAC_BITS] = 1'b0;
        end
        return v;
    endfunction

    // Sum of the outputs over one accumulator period
    // Zero sample sits at half of the unsigned range
    function automatic int expected_sum(input logic signed [`PCM_BITS-1:0] pcm);
        int off;
        off = int'(pcm) + (1 << (`PCM_BITS - 1));
        if ((off >> (`PCM_BITS - `DAC_BITS)) == int'(DAC_TOP)) begin
            return FULL_SUM;
        end else begin
            return off;
        end
    endfunction

    // Holds valid with a fresh sample after every transfer, ends right after one
    task automatic stream_samples(input int frames);
        int  cyc;
        logic done;
        cyc  = 0;
        done = 1'b0;
        sample       = rand_sample();
        sample_valid = 1'b1;
        while (!done) begin
            @(negedge clk_2x);
            cyc = cyc + 1;
            if (xfer_hist[0]) begin
                if (cyc >= frames * `DAC_FRAME) begin
                    done = 1'b1;
                end else begin
                    sample = rand_sample();
                end
            end
        end
        sample_valid = 1'b0;
    endtask

    task automatic offer_sample(input stereo_sample_t s);
        sample       = s;
        sample_valid = 1'b1;
        while (!sample_ready) @(negedge clk_2x);
        @(negedge clk_2x);
        sample_valid = 1'b0;
    endtask

    task automatic check_average(input stereo_sample_t s);
        exp_l = expected_sum(s.left);
        exp_r = expected_sum(s.right);
        offer_sample(s);
        // A sample still in the latch goes first, so wait two frames
        repeat (2 * `DAC_FRAME) @(negedge clk_2x);
        sum_l = 0;
        sum_r = 0;
        repeat (AVG_CYCLES) begin
            sum_l = sum_l + int'(dac_l);
            sum_r = sum_r + int'(dac_r);
            @(negedge clk_2x);
        end
        avg_chk = 1'b1;
        @(negedge clk_2x);
        avg_chk = 1'b0;
    endtask

    task automatic expect_pad(input logic exp_bit);
        pad_exp = exp_bit;
        pad_chk = 1'b1;
        @(negedge clk_2x);
        pad_chk = 1'b0;
    endtask

    // One pad_clk edge every 6 cycles, data checked 4 cycles after the edge
    task automatic pulse_pad_clk(input logic exp_bit);
        pad_clk   = 1'b1;
        board_btn = rand_buttons();
        repeat (3) @(negedge clk_2x);
        pad_clk = 1'b0;
        @(negedge clk_2x);
        expect_pad(exp_bit);
        @(negedge clk_2x);
    endtask

    task automatic pulse_pad_latch(input logic first_bit);
        pad_latch = 1'b1;
        board_btn = rand_buttons();
        @(negedge clk_2x);
        expect_pad(first_bit);
        pad_latch = 1'b0;
        expect_pad(first_bit);
    endtask

    task automatic read_pad(input logic [`PAD_BUTTONS-1:0] btn);
        logic [`PAD_BUTTONS-1:0] rest;
        rest    = btn;
        usb_btn = btn;
        repeat (4) @(negedge clk_2x);
        pulse_pad_latch(btn[0]);
        repeat (`PAD_BUTTONS) begin
            rest = {1'b1, rest[`PAD_BUTTONS-1:1]};
            pulse_pad_clk(rest[0]);
        end
        // Still ones past the last button
        pulse_pad_clk(1'b1);
    endtask

    task automatic relatch_mid_read(input logic [`PAD_BUTTONS-1:0] btn_in);
        logic [`PAD_BUTTONS-1:0] btn;
        logic [`PAD_BUTTONS-1:0] rest;
        btn    = btn_in;
        // Bit 0 differs from bit 5, where the read is cut off
        btn[0] = ~btn[5];
        rest   = btn;
        usb_btn = btn;
        repeat (4) @(negedge clk_2x);
        pulse_pad_latch(btn[0]);
        repeat (5) begin
            rest = {1'b1, rest[`PAD_BUTTONS-1:1]};
            pulse_pad_clk(rest[0]);
        end
        read_pad(btn);
    endtask

    initial begin
        stereo_sample_t s;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        usb_btn      = '0;
        board_btn    = '0;
        pad_latch    = 1'b0;
        pad_clk      = 1'b0;
        reset_chk    = 1'b0;
        avg_chk      = 1'b0;
        pad_chk      = 1'b0;
        pad_exp      = 1'b1;
        sum_l        = 0;
        sum_r        = 0;
        exp_l        = 0;
        exp_r        = 0;
        repeat (RESET_CYCLES) @(posedge clk_2x);
        @(negedge clk_2x);
        rst_n = 1'b1;
        @(negedge clk_2x);
        reset_chk = 1'b1;
        @(negedge clk_2x);
        reset_chk = 1'b0;

        stream_samples(10);

        for (int i = 0; i < 3; i++) begin
            s       = rand_sample();
            s.left  = below_full_scale(s.left);
            s.right = below_full_scale(s.right);
            check_average(s);
        end
        s.left  = PCM_MAX;
        s.right = PCM_MAX;
        check_average(s);

        read_pad(rand_buttons());
        read_pad(rand_buttons());
        relatch_mid_read(rand_buttons());

        repeat (4) @(negedge clk_2x);
        $display("Run complete with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Run limit with some margin over the expected length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_2x);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_cnt);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/audio_pkg.sv
rtl/pad_pkg.sv
rtl/audio_sample_latch.sv
rtl/audio_dac_sd.sv
rtl/pad_button_sync.sv
rtl/pad_shift_reg.sv
rtl/periph_top.sv
dv/tb_periph_top.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the peripheral block testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_periph_top -o tb_periph_top

./obj_dir/tb_periph_top | tee "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
